// ==== sim.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/axil_pkg.sv
hdl/register_file.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/exec_control.sv
hdl/exec_unit_top.sv
dv/exec_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module exec_unit_tb -o exec_unit_sim \
    && ./obj_dir/exec_unit_sim | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== dv/exec_unit_tb.sv ====
// Random-stimulus testbench for the RV32I execute unit
// AXI4-Lite host driver and a reference register model
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module exec_unit_tb
    import rv_isa_pkg::*, axil_pkg::*;
();

    localparam int num_random    = 200;
    localparam int num_x0        = 10;
    localparam int num_illegal   = 30;
    localparam int num_bad_reads = 20;
    // Full register sweeps after reset and after the illegal words
    localparam int num_transactions = 64 + 2 * num_random + 2 * num_x0 + num_illegal
                                      + num_bad_reads;
    localparam int cycle_limit = num_transactions * 12 + 200;

    localparam opcode_t op_reg = 7'b0110011;
    localparam opcode_t op_imm = 7'b0010011;
    localparam opcode_t op_lui = 7'b0110111;

    logic                  clock;
    logic                  reset;
    axil_addr_t            awaddr;
    logic                  awvalid;
    logic                  awready;
    data_word_t            wdata;
    logic [`RV_XLEN/8-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    axil_resp_t            bresp;
    logic                  bvalid;
    logic                  bready;
    axil_addr_t            araddr;
    logic                  arvalid;
    logic                  arready;
    data_word_t            rdata;
    axil_resp_t            rresp;
    logic                  rvalid;
    logic                  rready;

    integer     seed = 90164;
    data_word_t model [32]; // Expected architectural registers
    string      test_name;
    int         test_checks;
    int         test_errors;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         total_checks = 0;
    int         errors = 0;
    int         cycles = 0;

    exec_unit_top uut (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        assert (actual == expected) else begin
            $display("ERR %s expected %h actual %h", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("%-14s checks %0d errors %0d", test_name, test_checks, test_errors);
        tests_run++;
        total_checks += test_checks;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    function automatic int rand_range(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic axil_addr_t reg_addr(input int n);
        return axil_addr_t'(int'(`RV_ADDR_REG_BASE) + 4 * n);
    endfunction

    // Reference result from the RV32I rules
    function automatic data_word_t model_exec(input instr_word_t ins);
        data_word_t a;
        data_word_t b;
        logic       alt;
        a   = model[ins[19:15]];
        alt = (ins[6:0] == op_reg) && ins[30];
        if (ins[6:0] == op_lui) begin
            return {ins[31:12], 12'h000};
        end
        if (ins[6:0] == op_reg) begin
            b = model[ins[24:20]];
        end else begin
            b = {{20{ins[31]}}, ins[31:20]};
        end
        case (ins[14:12])
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (ins[30]) begin
                    return $signed(a) >>> b[4:0]; // Sign fills from bit 31
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic instr_word_t random_legal();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        int          kind;
        kind  = rand_range(3);
        f3    = 3'(rand_range(8));
        rd    = 5'(rand_range(32));
        rs1   = 5'(rand_range(32));
        rs2   = 5'(rand_range(32));
        imm12 = 12'($random(seed));
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && rand_range(2) == 1) ? 7'h20 : 7'h00;
        case (kind)
            0: return {f7, rs2, rs1, f3, rd, op_reg};
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm12 = {(f3 == 3'd5) ? f7 : 7'h00, imm12[4:0]}; // shamt form
                end
                return {imm12, rs1, f3, rd, op_imm};
            end
            default: return {20'($random(seed)), rd, op_lui};
        endcase
    endfunction

    task automatic make_illegal(output axil_addr_t addr, output instr_word_t word);
        opcode_t    opc;
        logic [6:0] f7;
        addr = `RV_ADDR_INSTR;
        word = instr_word_t'($random(seed));
        f7   = 7'($random(seed)) | 7'h01; // Never 0x00 or 0x20
        case (rand_range(4))
            0: begin
                opc = word[6:0];
                while (opc == op_reg || opc == op_imm || opc == op_lui) begin
                    opc = 7'($random(seed));
                end
                word[6:0] = opc;
            end
            1: begin
                word[31:25] = f7;
                word[6:0]   = op_reg;
            end
            2: begin
                word[31:25] = f7;
                word[14:12] = (rand_range(2) == 1) ? 3'd1 : 3'd5;
                word[6:0]   = op_imm;
            end
            default: begin
                word = random_legal();
                addr = axil_addr_t'(rand_range(255) + 1); // Anything but the instruction port
            end
        endcase
    endtask

    // Ready held low 0 to 3 cycles, response must not move meanwhile
    task automatic stall_and_accept(input logic is_read);
        logic [33:0] held;
        int          stall;
        held  = is_read ? {rresp, rdata} : {bresp, 32'h0};
        stall = rand_range(4);
        repeat (stall) begin
            @(negedge clock);
            assert ((is_read ? rvalid : bvalid) &&
                    held == (is_read ? {rresp, rdata} : {bresp, 32'h0}))
            else report_failure("response valid or payload changed during a stall");
        end
        @(posedge clock);
        if (is_read) begin
            rready <= 1'b1;
        end else begin
            bready <= 1'b1;
        end
        @(posedge clock); // Handshake edge
        rready <= 1'b0;
        bready <= 1'b0;
    endtask

    task automatic write_instr(input axil_addr_t addr, input instr_word_t word,
                               output axil_resp_t resp);
        int latency;
        @(posedge clock);
        awaddr  <= addr;
        wdata   <= word;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clock);
        while (!awready) @(negedge clock);
        assert (wready) else report_failure("wready was low while awready was high");
        @(posedge clock); // Accept edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        latency = 0;
        do begin
            @(negedge clock);
            latency++;
        end while (!bvalid);
        check_value({test_name, " bvalid latency"}, 32'd2, 32'(latency));
        resp = bresp;
        stall_and_accept(1'b0);
    endtask

    task automatic read_addr(input axil_addr_t addr, output data_word_t data,
                             output axil_resp_t resp);
        @(posedge clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clock);
        while (!arready) @(negedge clock);
        @(posedge clock);
        arvalid <= 1'b0;
        @(negedge clock);
        assert (rvalid) else report_failure("rvalid was low the cycle after the read accept");
        while (!rvalid) @(negedge clock);
        data = rdata;
        resp = rresp;
        stall_and_accept(1'b1);
    endtask

    task automatic check_reg(input int n);
        data_word_t data;
        axil_resp_t resp;
        read_addr(reg_addr(n), data, resp);
        check_value($sformatf("%s x%0d", test_name, n), model[n], data);
        check_value({test_name, " rresp"}, 32'(resp_okay), 32'(resp));
    endtask

    initial begin
        int          i;
        data_word_t  data;
        data_word_t  expected;
        axil_resp_t  resp;
        axil_addr_t  addr;
        instr_word_t word;
        reg_idx_t    rd;
        reset   <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '1;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        for (i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b1;

        start_test("reset_values");
        for (i = 0; i < 32; i++) begin
            check_reg(i);
        end
        finish_test();

        start_test("random_alu");
        for (i = 0; i < num_random; i++) begin
            word     = random_legal();
            rd       = word[11:7];
            expected = model_exec(word);
            write_instr(`RV_ADDR_INSTR, word, resp);
            check_value({test_name, " bresp"}, 32'(resp_okay), 32'(resp));
            if (rd != '0) begin
                model[rd] = expected;
            end
            check_reg(int'(rd));
        end
        finish_test();

        start_test("x0_writes");
        for (i = 0; i < num_x0; i++) begin
            word       = random_legal();
            word[11:7] = '0; // rd = x0
            write_instr(`RV_ADDR_INSTR, word, resp);
            check_value({test_name, " bresp"}, 32'(resp_okay), 32'(resp));
            check_reg(0);
        end
        finish_test();

        start_test("illegal_words");
        for (i = 0; i < num_illegal; i++) begin
            make_illegal(addr, word);
            write_instr(addr, word, resp);
            check_value($sformatf("%s bresp %h", test_name, word), 32'(resp_slverr),
                        32'(resp));
        end
        for (i = 0; i < 32; i++) begin
            check_reg(i); // Nothing may have changed
        end
        finish_test();

        start_test("bad_read_addr");
        for (i = 0; i < num_bad_reads; i++) begin
            addr = axil_addr_t'(rand_range(int'(`RV_ADDR_REG_BASE)));
            read_addr(addr, data, resp);
            check_value({test_name, " rdata"}, 32'd0, data);
            check_value({test_name, " rresp"}, 32'(resp_slverr), 32'(resp));
        end
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/exec_unit_top.sv ====
// Top level of the RV32I execute unit
// Control FSM, decoder, register file and ALU behind an AXI4-Lite slave
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module exec_unit_top
    import rv_isa_pkg::*, axil_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  axil_addr_t             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  data_word_t             wdata,
    input  logic [`RV_XLEN/8-1:0]  wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output axil_resp_t             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  axil_addr_t             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output data_word_t             rdata,
    output axil_resp_t             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    instr_word_t instruction;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    reg_idx_t    rd_idx;
    reg_idx_t    dbg_idx;
    alu_op_t     alu_op;
    data_word_t  imm;
    data_word_t  rs1_data;
    data_word_t  rs2_data;
    data_word_t  dbg_data;
    data_word_t  result;
    logic        use_imm;
    logic        legal;
    logic        wr_en;

    exec_control u_control (
        .clock       (clock),
        .reset       (reset),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .instruction (instruction),
        .legal       (legal),
        .rd_idx      (rd_idx),
        .wr_en       (wr_en),
        .dbg_idx     (dbg_idx),
        .dbg_data    (dbg_data)
    );

    instr_decoder u_decoder (
        .instruction (instruction),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx),
        .alu_op      (alu_op),
        .imm         (imm),
        .use_imm     (use_imm),
        .legal       (legal)
    );

    register_file u_regs (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rd_idx   (rd_idx),
        .dbg_idx  (dbg_idx),
        .wr_en    (wr_en),
        .wr_data  (result), // ALU result is the only writeback source
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

    alu u_alu (
        .alu_op   (alu_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .use_imm  (use_imm),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== hdl/exec_control.sv ====
// AXI4-Lite slave FSM: instruction latch, execute and writeback sequencing,
// and register readback
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module exec_control
    import rv_isa_pkg::*, axil_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  axil_addr_t             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  data_word_t             wdata,
    input  logic [`RV_XLEN/8-1:0]  wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output axil_resp_t             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  axil_addr_t             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output data_word_t             rdata,
    output axil_resp_t             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output instr_word_t            instruction,
    input  logic                   legal,
    input  reg_idx_t               rd_idx,
    output logic                   wr_en,
    output reg_idx_t               dbg_idx,
    input  data_word_t             dbg_data
);

    localparam axil_addr_t window_size = axil_addr_t'(4 << `RV_REG_IDX_W);

    ctrl_state_t state;
    logic        addr_ok;    // Write went to the instruction port
    logic        executed;
    logic        write_pair;
    axil_addr_t  reg_offset;
    logic        in_window;

    // Both write channels needed, writes win over reads
    assign write_pair = awvalid && wvalid;
    assign awready    = (state == state_idle) && write_pair;
    assign wready     = awready;
    assign arready    = (state == state_idle) && arvalid && !write_pair;

    // Register window decode
    assign reg_offset = araddr - `RV_ADDR_REG_BASE;
    assign in_window  = (araddr >= `RV_ADDR_REG_BASE) && (reg_offset < window_size);
    assign dbg_idx    = reg_offset[`RV_REG_IDX_W+1:2];

    assign executed = legal && addr_ok;
    assign wr_en    = (state == state_execute) && executed && (rd_idx != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state  <= state_idle;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (awready) begin
                        state <= state_execute;
                    end else if (arready) begin
                        state  <= state_read_resp;
                        rvalid <= 1'b1;
                    end
                end
                state_execute: begin
                    state  <= state_write_resp; // Writeback happens on this edge
                    bvalid <= 1'b1;
                end
                state_write_resp: begin
                    if (bready) begin
                        state  <= state_idle;
                        bvalid <= 1'b0;
                    end
                end
                default: begin
                    if (rready) begin
                        state  <= state_idle;
                        rvalid <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clock) begin
        if (awready) begin
            instruction <= wdata; // wstrb ignored, whole words only
            addr_ok     <= (awaddr == `RV_ADDR_INSTR);
        end
        if (state == state_execute) begin
            bresp <= executed ? resp_okay : resp_slverr;
        end
        if (arready) begin
            rdata <= in_window ? dbg_data : '0;
            rresp <= in_window ? resp_okay : resp_slverr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// RV32I integer ALU with operand B select
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module alu
    import rv_isa_pkg::*;
(
    input  alu_op_t    alu_op,
    input  data_word_t rs1_data,
    input  data_word_t rs2_data,
    input  data_word_t imm,
    input  logic       use_imm,
    output data_word_t result
);

    data_word_t op_b;
    logic [4:0] shamt;

    assign op_b  = use_imm ? imm : rs2_data;
    assign shamt = op_b[4:0]; // Only low 5 bits shift

    always_comb begin
        case (alu_op)
            alu_add:  result = rs1_data + op_b;
            alu_sub:  result = rs1_data - op_b;
            alu_sll:  result = rs1_data << shamt;
            alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, rs1_data < op_b};
            alu_xor:  result = rs1_data ^ op_b;
            alu_srl:  result = rs1_data >> shamt;
            alu_sra:  result = data_word_t'($signed(rs1_data) >>> shamt);
            alu_or:   result = rs1_data | op_b;
            alu_and:  result = rs1_data & op_b;
            default:  result = op_b; // Pass B for LUI
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
// Decoder for RV32I R-type, OP-IMM and LUI instructions
// Produces register indices, ALU operation, immediate and legality
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module instr_decoder
    import rv_isa_pkg::*;
(
    input  instr_word_t instruction,
    output reg_idx_t    rs1_idx,
    output reg_idx_t    rs2_idx,
    output reg_idx_t    rd_idx,
    output alu_op_t     alu_op,
    output data_word_t  imm,
    output logic        use_imm,
    output logic        legal
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    // Shared funct3 map, alt selects SUB or SRA
    function automatic alu_op_t map_op(input funct3_t f3, input logic alt);
        case (f3)
            3'b000:  map_op = alt ? alu_sub : alu_add;
            3'b001:  map_op = alu_sll;
            3'b010:  map_op = alu_slt;
            3'b011:  map_op = alu_sltu;
            3'b100:  map_op = alu_xor;
            3'b101:  map_op = alt ? alu_sra : alu_srl;
            3'b110:  map_op = alu_or;
            default: map_op = alu_and;
        endcase
    endfunction

    assign opcode  = instruction[6:0];
    assign funct3  = instruction[14:12];
    assign funct7  = instruction[31:25];
    assign rs2_idx = instruction[24:20];
    assign rd_idx  = instruction[11:7];

    always_comb begin
        rs1_idx = instruction[19:15];
        alu_op  = alu_add;
        imm     = {{(`RV_XLEN-12){instruction[31]}}, instruction[31:20]}; // I immediate
        use_imm = 1'b0;
        legal   = 1'b0;
        case (opcode)
            opc_op: begin
                alu_op = map_op(funct3, funct7 == f7_alt);
                legal  = (funct7 == f7_base) || (funct7 == f7_alt);
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    // Shift by shamt, funct7 picks logical or arithmetic
                    imm    = {{(`RV_XLEN-5){1'b0}}, instruction[24:20]};
                    alu_op = map_op(funct3, funct7 == f7_alt);
                    legal  = (funct7 == f7_base) || (funct7 == f7_alt);
                end else begin
                    alu_op = map_op(funct3, 1'b0); // No SUBI
                    legal  = 1'b1;
                end
            end
            opc_lui: begin
                rs1_idx = '0;
                alu_op  = alu_pass_b;
                imm     = {instruction[31:12], 12'b0}; // U immediate
                use_imm = 1'b1;
                legal   = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
// 32-entry integer register file, x0 reads as zero
// Two operand read ports and a debug read port
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module register_file
    import rv_isa_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  reg_idx_t   rs1_idx,
    input  reg_idx_t   rs2_idx,
    input  reg_idx_t   rd_idx,
    input  reg_idx_t   dbg_idx,
    input  logic       wr_en,
    input  data_word_t wr_data,
    output data_word_t rs1_data,
    output data_word_t rs2_data,
    output data_word_t dbg_data
);

    localparam int num_regs = 1 << `RV_REG_IDX_W;

    data_word_t regs [num_regs];

    // Index 0 is hardwired to zero on every read port
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    assign dbg_data = (dbg_idx == '0) ? '0 : regs[dbg_idx];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axil_pkg.sv ====
// Bus-side types: AXI4-Lite address, response code, control FSM states
`default_nettype none
`include "rv_settings.svh"

package axil_pkg;

    typedef logic [`RV_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [1:0]                 axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    typedef enum logic [1:0] {
        state_idle,
        state_execute,
        state_write_resp,
        state_read_resp
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
// RV32I types: data word, register index, opcode, funct fields, ALU operations
`default_nettype none
`include "rv_settings.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0]      data_word_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [31:0]              instr_word_t;
    typedef logic [6:0]               opcode_t;
    typedef logic [2:0]               funct3_t;
    typedef logic [6:0]               funct7_t;

    // Major opcodes handled by the decoder
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui    = 7'b0110111;

    localparam funct7_t f7_base = 7'h00;
    localparam funct7_t f7_alt  = 7'h20; // SUB and SRA

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // LUI
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hdl/rv_settings.svh ====
// Width and address map macros for the RV32I execute unit
// Shared by the packages and the RTL modules
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath widths
`define RV_XLEN          32
`define RV_REG_IDX_W     5

// AXI4-Lite address width
`define RV_AXIL_ADDR_W   8

// Instruction write port
`define RV_ADDR_INSTR    8'h00

// Register n is read at base + 4n
`define RV_ADDR_REG_BASE 8'h80

`endif
